// ==== hdl/pong_pkg.sv ====
package pong_pkg;

	// colour byte rrr_ggg_bb
	typedef logic [7:0] pixel_t;

	// raster counts, wide enough for 1024x768 plus blanking
	typedef logic [10:0] hcount_t;
	typedef logic [9:0] vcount_t;

	// sideband that rides along with each pixel
	typedef struct packed {
		logic hsync;
		logic vsync;
		logic video_on;
	} sync_t;

	// compositor source select
	typedef enum logic [1:0] {
		mode_game,
		mode_border,
		mode_bars,
		mode_game_alt
	} mode_t;

	// per-axis speed field from software
	typedef logic [1:0] speed_t;

	// object geometry in pixels
	localparam int PUCK_SIZE = 64;
	localparam int PADDLE_W = 16;
	localparam int PADDLE_H = 128;
	localparam int PADDLE_STEP = 8;
	localparam int PADDLE_MARGIN = 20;
	localparam int PUCK_MIN_X = 5;
	localparam int PUCK_MIN_Y = 1;

	localparam pixel_t PUCK0_COLOR = 8'b111_000_11;
	localparam pixel_t PUCK1_COLOR = 8'b111_111_00;
	localparam pixel_t PADDLE_COLOR = 8'b000_111_00;

	// stages between raster count and puck colour
	localparam int RENDER_DELAY = 2;

endpackage

// ==== hdl/video_timing_if.sv ====
`timescale 1ns/100ps

interface video_timing_if import pong_pkg::*; ();

	// raster position of the current pixel
	hcount_t hcount;
	vcount_t vcount;

	// active-low syncs, active-high video window
	logic hsync;
	logic vsync;
	logic video_on;

	modport source (output hcount, vcount, hsync, vsync, video_on);
	modport sink (input hcount, vcount, hsync, vsync, video_on);

endinterface

// ==== hdl/video_timing.sv ====
`timescale 1ns/100ps

module video_timing import pong_pkg::*; #(
	parameter int H_ACTIVE = 1024,
	parameter int H_FP = 24,
	parameter int H_SYNC = 136,
	parameter int H_BP = 160,
	parameter int V_ACTIVE = 768,
	parameter int V_FP = 3,
	parameter int V_SYNC = 6,
	parameter int V_BP = 29
) (
	input logic pixel_clk,
	input logic reset,
	video_timing_if.source vt,
	output logic frame_pulse
);

	localparam int H_TOTAL = H_ACTIVE + H_FP + H_SYNC + H_BP;
	localparam int V_TOTAL = V_ACTIVE + V_FP + V_SYNC + V_BP;
	localparam int H_SYNC_START = H_ACTIVE + H_FP;
	localparam int V_SYNC_START = V_ACTIVE + V_FP;

	logic h_end;
	logic v_end;
	logic vsync_prev;

	// last pixel of a line, last line of a frame
	assign h_end = (vt.hcount == hcount_t'(H_TOTAL - 1));
	assign v_end = (vt.vcount == vcount_t'(V_TOTAL - 1));

	always_ff @(posedge pixel_clk or posedge reset) begin
		if (reset) begin
			vt.hcount <= '0;
			vt.vcount <= '0;
			vsync_prev <= 1'b1;
		end else begin
			vt.hcount <= h_end ? '0 : vt.hcount + 1'b1;
			// line count steps once per wrap
			if (h_end) begin
				vt.vcount <= v_end ? '0 : vt.vcount + 1'b1;
			end
			vsync_prev <= vt.vsync;
		end
	end

	// sync low from end of front porch through sync width
	assign vt.hsync = !((vt.hcount >= hcount_t'(H_SYNC_START)) &&
		(vt.hcount < hcount_t'(H_SYNC_START + H_SYNC)));
	assign vt.vsync = !((vt.vcount >= vcount_t'(V_SYNC_START)) &&
		(vt.vcount < vcount_t'(V_SYNC_START + V_SYNC)));
	assign vt.video_on = (vt.hcount < hcount_t'(H_ACTIVE)) && (vt.vcount < vcount_t'(V_ACTIVE));

	// one cycle, first cycle with vsync low
	assign frame_pulse = vsync_prev && !vt.vsync;

endmodule

// ==== hdl/pong_regs.sv ====
`timescale 1ns/100ps

module pong_regs import pong_pkg::*; (
	input logic pixel_clk,
	input logic reset,
	input logic wb_cyc,
	input logic wb_stb,
	input logic wb_we,
	input logic wb_adr,
	input logic [7:0] wb_dat_w,
	output logic [7:0] wb_dat_r,
	output logic wb_ack,
	output mode_t mode,
	output speed_t speed_x,
	output speed_t speed_y
);

	logic req;
	logic [7:0] rd_data;

	// new request, not the tail of the one being acked
	assign req = wb_cyc && wb_stb && !wb_ack;

	// unused bits read back as zero
	assign rd_data = wb_adr ? {4'b0000, speed_x, speed_y} : {6'b000000, mode};

	always_ff @(posedge pixel_clk or posedge reset) begin
		if (reset) begin
			wb_ack <= 1'b0;
			mode <= mode_game;
			speed_x <= 2'd1;
			speed_y <= 2'd1;
		end else begin
			// single-cycle ack
			wb_ack <= req;
			if (req && wb_we) begin
				if (wb_adr) begin
					speed_x <= wb_dat_w[3:2];
					speed_y <= wb_dat_w[1:0];
				end else begin
					mode <= mode_t'(wb_dat_w[1:0]);
				end
			end
		end
	end

	// read data captured with the ack
	always_ff @(posedge pixel_clk) begin
		if (req) begin
			wb_dat_r <= rd_data;
		end
	end

endmodule

// ==== hdl/puck_motion.sv ====
`timescale 1ns/100ps

module puck_motion import pong_pkg::*; #(
	parameter int H_ACTIVE = 1024,
	parameter int V_ACTIVE = 768,
	parameter int START_X = 256,
	parameter int START_Y = 192,
	parameter bit START_RIGHT = 1'b1,
	parameter bit START_DOWN = 1'b1
) (
	input logic pixel_clk,
	input logic reset,
	input logic frame_pulse,
	input speed_t speed_x,
	input speed_t speed_y,
	output hcount_t puck_x,
	output vcount_t puck_y
);

	// upper left corner limits
	localparam int MAX_X = H_ACTIVE - PUCK_SIZE;
	localparam int MAX_Y = V_ACTIVE - PUCK_SIZE;

	logic moving_right;
	logic moving_down;
	int next_x;
	int next_y;

	// step is twice the speed field
	always_comb begin
		next_x = moving_right ? int'(puck_x) + 2 * int'(speed_x) : int'(puck_x) - 2 * int'(speed_x);
		next_y = moving_down ? int'(puck_y) + 2 * int'(speed_y) : int'(puck_y) - 2 * int'(speed_y);
	end

	always_ff @(posedge pixel_clk or posedge reset) begin
		if (reset) begin
			puck_x <= hcount_t'(START_X);
			puck_y <= vcount_t'(START_Y);
			moving_right <= START_RIGHT;
			moving_down <= START_DOWN;
		end else if (frame_pulse) begin
			// horizontal, clamp and bounce at either edge
			if (next_x < PUCK_MIN_X) begin
				puck_x <= hcount_t'(PUCK_MIN_X);
				moving_right <= 1'b1;
			end else if (next_x > MAX_X) begin
				puck_x <= hcount_t'(MAX_X);
				moving_right <= 1'b0;
			end else begin
				puck_x <= hcount_t'(next_x);
			end
			// vertical, same rule
			if (next_y < PUCK_MIN_Y) begin
				puck_y <= vcount_t'(PUCK_MIN_Y);
				moving_down <= 1'b1;
			end else if (next_y > MAX_Y) begin
				puck_y <= vcount_t'(MAX_Y);
				moving_down <= 1'b0;
			end else begin
				puck_y <= vcount_t'(next_y);
			end
		end
	end

endmodule

// ==== hdl/paddle_motion.sv ====
`timescale 1ns/100ps

module paddle_motion import pong_pkg::*; #(
	parameter int H_ACTIVE = 1024,
	parameter int V_ACTIVE = 768
) (
	input logic pixel_clk,
	input logic reset,
	input logic frame_pulse,
	input logic btn_up,
	input logic btn_down,
	input logic btn_left,
	input logic btn_right,
	output hcount_t paddle_x,
	output vcount_t paddle_y
);

	// far limits keep the whole paddle inside the margin
	localparam int X_MAX = H_ACTIVE - PADDLE_MARGIN - PADDLE_W;
	localparam int Y_MAX = V_ACTIVE - PADDLE_MARGIN - PADDLE_H;

	int up_y;
	int down_y;
	int left_x;
	int right_x;

	// candidate positions one step away
	always_comb begin
		up_y = int'(paddle_y) - PADDLE_STEP;
		down_y = int'(paddle_y) + PADDLE_STEP;
		left_x = int'(paddle_x) - PADDLE_STEP;
		right_x = int'(paddle_x) + PADDLE_STEP;
	end

	always_ff @(posedge pixel_clk or posedge reset) begin
		if (reset) begin
			paddle_x <= hcount_t'(PADDLE_MARGIN);
			paddle_y <= vcount_t'(PADDLE_MARGIN);
		end else if (frame_pulse) begin
			// up wins over down
			if (btn_up) begin
				if (up_y >= PADDLE_MARGIN) begin
					paddle_y <= vcount_t'(up_y);
				end
			end else if (btn_down && (down_y <= Y_MAX)) begin
				paddle_y <= vcount_t'(down_y);
			end
			// left wins over right
			if (btn_left) begin
				if (left_x >= PADDLE_MARGIN) begin
					paddle_x <= hcount_t'(left_x);
				end
			end else if (btn_right && (right_x <= X_MAX)) begin
				paddle_x <= hcount_t'(right_x);
			end
		end
	end

endmodule

// ==== hdl/round_puck.sv ====
`timescale 1ns/100ps

module round_puck import pong_pkg::*; #(
	parameter pixel_t COLOR = 8'b111_000_00
) (
	input logic pixel_clk,
	video_timing_if.sink vt,
	input hcount_t puck_x,
	input vcount_t puck_y,
	output pixel_t rpixel
);

	localparam int RADIUS = PUCK_SIZE / 2;
	localparam logic [22:0] R_SQ = 23'(RADIUS * RADIUS);

	int off_x;
	int off_y;
	logic [10:0] dx;
	logic [9:0] dy;
	logic [22:0] dist_sq;

	// signed offset from the puck centre
	always_comb begin
		off_x = int'(vt.hcount) - (int'(puck_x) + RADIUS);
		off_y = int'(vt.vcount) - (int'(puck_y) + RADIUS);
	end

	// stage 1, absolute distances
	always_ff @(posedge pixel_clk) begin
		dx <= 11'(off_x < 0 ? -off_x : off_x);
		dy <= 10'(off_y < 0 ? -off_y : off_y);
	end

	// squares zero-extended so the sum cannot wrap
	assign dist_sq = ({12'b0, dx} * {12'b0, dx}) + ({13'b0, dy} * {13'b0, dy});

	// stage 2, inside test
	always_ff @(posedge pixel_clk) begin
		rpixel <= (dist_sq <= R_SQ) ? COLOR : '0;
	end

endmodule

// ==== hdl/delay_line.sv ====
`timescale 1ns/100ps

module delay_line #(
	parameter type payload_t = logic [7:0],
	parameter int DEPTH = 2,
	parameter payload_t RESET_VALUE = '0
) (
	input logic pixel_clk,
	input logic reset,
	input payload_t din,
	output payload_t dout
);

	payload_t stages [DEPTH];

	// shift register, stage 0 takes the input
	always_ff @(posedge pixel_clk or posedge reset) begin
		if (reset) begin
			for (int i = 0; i < DEPTH; i++) begin
				stages[i] <= RESET_VALUE;
			end
		end else begin
			stages[0] <= din;
			for (int i = 1; i < DEPTH; i++) begin
				stages[i] <= stages[i - 1];
			end
		end
	end

	assign dout = stages[DEPTH - 1];

endmodule

// ==== hdl/pixel_mux.sv ====
`timescale 1ns/100ps

module pixel_mux import pong_pkg::*; #(
	parameter int H_ACTIVE = 1024,
	parameter int V_ACTIVE = 768
) (
	input logic pixel_clk,
	input logic reset,
	input mode_t mode,
	video_timing_if.sink vt,
	input sync_t game_sync,
	input pixel_t game_pixel,
	output sync_t out_sync,
	output pixel_t out_pixel
);

	localparam pixel_t WHITE = 8'hff;
	localparam sync_t SYNC_IDLE = '{hsync: 1'b1, vsync: 1'b1, video_on: 1'b0};

	logic on_border;
	pixel_t border_now;
	pixel_t bars_now;
	pixel_t border_pipe [2];
	pixel_t bars_pipe [2];
	pixel_t selected;

	//////////////////////////////////////////////////////////////////////
	// test patterns from the raw counts
	//////////////////////////////////////////////////////////////////////

	// outline of the active window
	assign on_border = (vt.hcount == '0) || (vt.hcount == hcount_t'(H_ACTIVE - 1)) ||
		(vt.vcount == '0) || (vt.vcount == vcount_t'(V_ACTIVE - 1));
	assign border_now = on_border ? WHITE : '0;

	// bars from three column bits
	assign bars_now = {{3{vt.hcount[8]}}, {3{vt.hcount[7]}}, {2{vt.hcount[6]}}};

	// two stages to line up with the puck renderers
	always_ff @(posedge pixel_clk) begin
		border_pipe[0] <= border_now;
		border_pipe[1] <= border_pipe[0];
		bars_pipe[0] <= bars_now;
		bars_pipe[1] <= bars_pipe[0];
	end

	//////////////////////////////////////////////////////////////////////
	// source select and blanking
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		case (mode)
			mode_border: selected = border_pipe[1];
			mode_bars: selected = bars_pipe[1];
			mode_game, mode_game_alt: selected = game_pixel;
			default: selected = game_pixel;
		endcase
	end

	always_ff @(posedge pixel_clk or posedge reset) begin
		if (reset) begin
			out_sync <= SYNC_IDLE;
			out_pixel <= '0;
		end else begin
			out_sync <= game_sync;
			// black outside the active window
			out_pixel <= game_sync.video_on ? selected : '0;
		end
	end

endmodule

// ==== hdl/pong_top.sv ====
`timescale 1ns/100ps

module pong_top import pong_pkg::*; #(
	parameter int H_ACTIVE = 1024,
	parameter int H_FP = 24,
	parameter int H_SYNC = 136,
	parameter int H_BP = 160,
	parameter int V_ACTIVE = 768,
	parameter int V_FP = 3,
	parameter int V_SYNC = 6,
	parameter int V_BP = 29
) (
	input logic pixel_clk,
	input logic reset,
	input logic btn_up,
	input logic btn_down,
	input logic btn_left,
	input logic btn_right,
	input logic wb_cyc,
	input logic wb_stb,
	input logic wb_we,
	input logic wb_adr,
	input logic [7:0] wb_dat_w,
	output logic [7:0] wb_dat_r,
	output logic wb_ack,
	output logic hsync,
	output logic vsync,
	output logic video_on,
	output logic [2:0] vga_red,
	output logic [2:0] vga_green,
	output logic [1:0] vga_blue
);

	// idle sideband while the pipe fills after reset
	localparam sync_t SYNC_IDLE = '{hsync: 1'b1, vsync: 1'b1, video_on: 1'b0};

	video_timing_if vt ();

	logic frame_pulse;
	mode_t mode;
	speed_t speed_x;
	speed_t speed_y;
	hcount_t puck0_x;
	vcount_t puck0_y;
	hcount_t puck1_x;
	vcount_t puck1_y;
	hcount_t paddle_x;
	vcount_t paddle_y;
	pixel_t puck0_pix;
	pixel_t puck1_pix;
	pixel_t paddle_pix;
	pixel_t paddle_pix_d;
	pixel_t game_pixel;
	pixel_t out_pixel;
	sync_t raw_sync;
	sync_t game_sync;
	sync_t out_sync;

	//////////////////////////////////////////////////////////////////////
	// raster and registers
	//////////////////////////////////////////////////////////////////////

	video_timing #(
		.H_ACTIVE(H_ACTIVE), .H_FP(H_FP), .H_SYNC(H_SYNC), .H_BP(H_BP),
		.V_ACTIVE(V_ACTIVE), .V_FP(V_FP), .V_SYNC(V_SYNC), .V_BP(V_BP)
	) i_video_timing (
		.pixel_clk(pixel_clk),
		.reset(reset),
		.vt(vt),
		.frame_pulse(frame_pulse)
	);

	pong_regs i_pong_regs (
		.pixel_clk(pixel_clk),
		.reset(reset),
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_we(wb_we),
		.wb_adr(wb_adr),
		.wb_dat_w(wb_dat_w),
		.wb_dat_r(wb_dat_r),
		.wb_ack(wb_ack),
		.mode(mode),
		.speed_x(speed_x),
		.speed_y(speed_y)
	);

	//////////////////////////////////////////////////////////////////////
	// object motion, once per frame
	//////////////////////////////////////////////////////////////////////

	// puck 0 from the upper quarter, heading right and down
	puck_motion #(
		.H_ACTIVE(H_ACTIVE), .V_ACTIVE(V_ACTIVE),
		.START_X(H_ACTIVE / 4), .START_Y(V_ACTIVE / 4),
		.START_RIGHT(1'b1), .START_DOWN(1'b1)
	) i_puck0_motion (
		.pixel_clk(pixel_clk),
		.reset(reset),
		.frame_pulse(frame_pulse),
		.speed_x(speed_x),
		.speed_y(speed_y),
		.puck_x(puck0_x),
		.puck_y(puck0_y)
	);

	// puck 1 from the middle, heading left and up
	puck_motion #(
		.H_ACTIVE(H_ACTIVE), .V_ACTIVE(V_ACTIVE),
		.START_X(H_ACTIVE / 2), .START_Y(V_ACTIVE / 2),
		.START_RIGHT(1'b0), .START_DOWN(1'b0)
	) i_puck1_motion (
		.pixel_clk(pixel_clk),
		.reset(reset),
		.frame_pulse(frame_pulse),
		.speed_x(speed_x),
		.speed_y(speed_y),
		.puck_x(puck1_x),
		.puck_y(puck1_y)
	);

	paddle_motion #(
		.H_ACTIVE(H_ACTIVE), .V_ACTIVE(V_ACTIVE)
	) i_paddle_motion (
		.pixel_clk(pixel_clk),
		.reset(reset),
		.frame_pulse(frame_pulse),
		.btn_up(btn_up),
		.btn_down(btn_down),
		.btn_left(btn_left),
		.btn_right(btn_right),
		.paddle_x(paddle_x),
		.paddle_y(paddle_y)
	);

	//////////////////////////////////////////////////////////////////////
	// rendering, all paths RENDER_DELAY deep
	//////////////////////////////////////////////////////////////////////

	round_puck #(.COLOR(PUCK0_COLOR)) i_puck0_render (
		.pixel_clk(pixel_clk),
		.vt(vt),
		.puck_x(puck0_x),
		.puck_y(puck0_y),
		.rpixel(puck0_pix)
	);

	round_puck #(.COLOR(PUCK1_COLOR)) i_puck1_render (
		.pixel_clk(pixel_clk),
		.vt(vt),
		.puck_x(puck1_x),
		.puck_y(puck1_y),
		.rpixel(puck1_pix)
	);

	// paddle rectangle hit, combinational from the counts
	assign paddle_pix = ((vt.hcount >= paddle_x) && (vt.hcount < paddle_x + PADDLE_W) &&
		(vt.vcount >= paddle_y) && (vt.vcount < paddle_y + PADDLE_H)) ? PADDLE_COLOR : '0;

	delay_line #(.payload_t(pixel_t), .DEPTH(RENDER_DELAY)) i_paddle_delay (
		.pixel_clk(pixel_clk),
		.reset(reset),
		.din(paddle_pix),
		.dout(paddle_pix_d)
	);

	assign raw_sync = '{hsync: vt.hsync, vsync: vt.vsync, video_on: vt.video_on};

	// syncs idle high out of reset
	delay_line #(
		.payload_t(sync_t), .DEPTH(RENDER_DELAY), .RESET_VALUE(SYNC_IDLE)
	) i_sync_delay (
		.pixel_clk(pixel_clk),
		.reset(reset),
		.din(raw_sync),
		.dout(game_sync)
	);

	// overlapping objects just mix
	assign game_pixel = puck0_pix | puck1_pix | paddle_pix_d;

	pixel_mux #(
		.H_ACTIVE(H_ACTIVE), .V_ACTIVE(V_ACTIVE)
	) i_pixel_mux (
		.pixel_clk(pixel_clk),
		.reset(reset),
		.mode(mode),
		.vt(vt),
		.game_sync(game_sync),
		.game_pixel(game_pixel),
		.out_sync(out_sync),
		.out_pixel(out_pixel)
	);

	assign hsync = out_sync.hsync;
	assign vsync = out_sync.vsync;
	assign video_on = out_sync.video_on;
	assign vga_red = out_pixel[7:5];
	assign vga_green = out_pixel[4:2];
	assign vga_blue = out_pixel[1:0];

endmodule

// ==== tests/tb_pong.sv ====
`timescale 1ns/100ps

module tb_pong import pong_pkg::*; ();

	// small raster so a frame is short
	localparam int H_ACTIVE = 160;
	localparam int H_FP = 4;
	localparam int H_SYNC = 8;
	localparam int H_BP = 8;
	localparam int V_ACTIVE = 120;
	localparam int V_FP = 2;
	localparam int V_SYNC = 3;
	localparam int V_BP = 2;
	localparam int H_TOTAL = H_ACTIVE + H_FP + H_SYNC + H_BP;
	localparam int V_TOTAL = V_ACTIVE + V_FP + V_SYNC + V_BP;
	localparam int CLK_PERIOD = 100;
	localparam int N_TESTS = 6;
	// ten frames per test
	localparam longint WATCHDOG_NS = 64'd10 * H_TOTAL * V_TOTAL * N_TESTS * CLK_PERIOD;

	// which compositor pattern the checks expect
	localparam int CHK_NONE = 0;
	localparam int CHK_BORDER = 1;
	localparam int CHK_BARS = 2;
	localparam int CHK_GAME = 3;

	logic pixel_clk;
	logic reset;
	logic btn_up;
	logic btn_down;
	logic btn_left;
	logic btn_right;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	logic wb_adr;
	logic [7:0] wb_dat_w;
	logic [7:0] wb_dat_r;
	logic wb_ack;
	logic hsync;
	logic vsync;
	logic video_on;
	logic [2:0] vga_red;
	logic [2:0] vga_green;
	logic [1:0] vga_blue;
	pixel_t colour;

	// bookkeeping
	int errors;
	int errors_at_start;
	int tests_done;
	int check_mode;

	// register shadow and expected read data
	logic [1:0] mode_sh;
	logic [1:0] spd_x;
	logic [1:0] spd_y;
	logic [7:0] exp_rdata;

	// scoreboard state sampled once per negedge
	logic hsync_q;
	logic vsync_q;
	logic video_on_q;
	logic h_fall;
	logic h_rise;
	logic v_fall;
	logic v_rise;
	int col;
	int row;
	int line_cycles;
	int hs_low;
	int lines;
	int vs_low_lines;
	int on_count;
	bit lines_seen;
	bit frames_seen;

	// object model
	int pk_x [2];
	int pk_y [2];
	bit pk_right [2];
	bit pk_down [2];
	int pad_x;
	int pad_y;

	pong_top #(
		.H_ACTIVE(H_ACTIVE), .H_FP(H_FP), .H_SYNC(H_SYNC), .H_BP(H_BP),
		.V_ACTIVE(V_ACTIVE), .V_FP(V_FP), .V_SYNC(V_SYNC), .V_BP(V_BP)
	) i_dut (
		.pixel_clk(pixel_clk),
		.reset(reset),
		.btn_up(btn_up),
		.btn_down(btn_down),
		.btn_left(btn_left),
		.btn_right(btn_right),
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_we(wb_we),
		.wb_adr(wb_adr),
		.wb_dat_w(wb_dat_w),
		.wb_dat_r(wb_dat_r),
		.wb_ack(wb_ack),
		.hsync(hsync),
		.vsync(vsync),
		.video_on(video_on),
		.vga_red(vga_red),
		.vga_green(vga_green),
		.vga_blue(vga_blue)
	);

	assign colour = {vga_red, vga_green, vga_blue};

	initial begin
		pixel_clk = 1'b0;
		forever #(CLK_PERIOD / 2) pixel_clk = ~pixel_clk;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired, the tests did not finish in time");
		$display("Some tests failed");
		$finish;
	end

	//////////////////////////////////////////////////////////////////////
	// expected values
	//////////////////////////////////////////////////////////////////////

	task automatic log_failure(input string msg);
		errors++;
		$display("CHECK FAILED at %0d ns: %s", $time, msg);
	endtask

	function automatic pixel_t border_color(int x, int y);
		if (x == 0 || x == H_ACTIVE - 1 || y == 0 || y == V_ACTIVE - 1) begin
			return 8'hff;
		end
		return 8'h00;
	endfunction

	// 64-column bands whose index bits drive red, green and blue
	function automatic pixel_t bar_color(int x);
		int band;
		band = (x / 64) % 8;
		return {{3{band[2]}}, {3{band[1]}}, {2{band[0]}}};
	endfunction

	function automatic bit inside_puck(int x, int y, int px, int py);
		int dx;
		int dy;
		dx = x - (px + PUCK_SIZE / 2);
		dy = y - (py + PUCK_SIZE / 2);
		return (dx * dx + dy * dy) <= (PUCK_SIZE / 2) * (PUCK_SIZE / 2);
	endfunction

	// overlapping objects OR together
	function automatic pixel_t game_color(int x, int y);
		pixel_t c;
		c = '0;
		if (inside_puck(x, y, pk_x[0], pk_y[0])) begin
			c = c | PUCK0_COLOR;
		end
		if (inside_puck(x, y, pk_x[1], pk_y[1])) begin
			c = c | PUCK1_COLOR;
		end
		if (x >= pad_x && x < pad_x + PADDLE_W &&
			y >= pad_y && y < pad_y + PADDLE_H) begin
			c = c | PADDLE_COLOR;
		end
		return c;
	endfunction

	// one axis of the bounce rule
	task automatic bounce(input int pos, input int step, input bit fwd, input int lo,
		input int hi, output int new_pos, output bit new_fwd);
		int nxt;
		nxt = fwd ? pos + step : pos - step;
		new_pos = nxt;
		new_fwd = fwd;
		if (nxt < lo) begin
			new_pos = lo;
			new_fwd = 1'b1;
		end else if (nxt > hi) begin
			new_pos = hi;
			new_fwd = 1'b0;
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// raster scoreboard rebuilt from the output syncs
	//////////////////////////////////////////////////////////////////////

	assign h_fall = hsync_q && !hsync;
	assign h_rise = !hsync_q && hsync;
	assign v_fall = vsync_q && !vsync;
	assign v_rise = !vsync_q && vsync;

	always @(negedge pixel_clk) begin
		if (reset) begin
			hsync_q <= 1'b1;
			vsync_q <= 1'b1;
			video_on_q <= 1'b0;
			col <= 0;
			row <= 0;
			line_cycles <= 0;
			hs_low <= 0;
			lines <= 0;
			vs_low_lines <= 0;
			on_count <= 0;
			lines_seen <= 1'b0;
			frames_seen <= 1'b0;
		end else begin
			hsync_q <= hsync;
			vsync_q <= vsync;
			video_on_q <= video_on;
			// column counts active pixels so far in the line
			col <= video_on ? col + 1 : 0;
			line_cycles <= h_fall ? 1 : line_cycles + 1;
			hs_low <= hsync ? 0 : hs_low + 1;
			if (h_fall) begin
				lines_seen <= 1'b1;
			end
			if (v_fall) begin
				row <= 0;
				lines <= 0;
				vs_low_lines <= 0;
				on_count <= 0;
				frames_seen <= 1'b1;
			end else begin
				// row steps at the end of each active line
				if (video_on_q && !video_on) begin
					row <= row + 1;
				end
				if (h_fall) begin
					lines <= lines + 1;
				end
				if (h_fall && !vsync) begin
					vs_low_lines <= vs_low_lines + 1;
				end
				if (video_on) begin
					on_count <= on_count + 1;
				end
			end
		end
	end

	// objects step once per frame on the output vsync fall
	always @(negedge pixel_clk) begin : motion_model
		int nx;
		int ny;
		bit nr;
		bit nd;
		if (reset) begin
			pk_x[0] <= H_ACTIVE / 4;
			pk_y[0] <= V_ACTIVE / 4;
			pk_right[0] <= 1'b1;
			pk_down[0] <= 1'b1;
			pk_x[1] <= H_ACTIVE / 2;
			pk_y[1] <= V_ACTIVE / 2;
			pk_right[1] <= 1'b0;
			pk_down[1] <= 1'b0;
			pad_x <= PADDLE_MARGIN;
			pad_y <= PADDLE_MARGIN;
		end else if (v_fall) begin
			for (int i = 0; i < 2; i++) begin
				bounce(pk_x[i], 2 * int'(spd_x), pk_right[i], PUCK_MIN_X,
					H_ACTIVE - PUCK_SIZE, nx, nr);
				bounce(pk_y[i], 2 * int'(spd_y), pk_down[i], PUCK_MIN_Y,
					V_ACTIVE - PUCK_SIZE, ny, nd);
				pk_x[i] <= nx;
				pk_y[i] <= ny;
				pk_right[i] <= nr;
				pk_down[i] <= nd;
			end
			// up over down and left over right
			if (btn_up) begin
				if (pad_y - PADDLE_STEP >= PADDLE_MARGIN) begin
					pad_y <= pad_y - PADDLE_STEP;
				end
			end else if (btn_down &&
				pad_y + PADDLE_STEP <= V_ACTIVE - PADDLE_MARGIN - PADDLE_H) begin
				pad_y <= pad_y + PADDLE_STEP;
			end
			if (btn_left) begin
				if (pad_x - PADDLE_STEP >= PADDLE_MARGIN) begin
					pad_x <= pad_x - PADDLE_STEP;
				end
			end else if (btn_right &&
				pad_x + PADDLE_STEP <= H_ACTIVE - PADDLE_MARGIN - PADDLE_W) begin
				pad_x <= pad_x + PADDLE_STEP;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// assertions
	//////////////////////////////////////////////////////////////////////

	a_ack_follows_req: assert property (@(negedge pixel_clk) disable iff (reset)
		(wb_cyc && wb_stb && !wb_ack) |=> wb_ack)
		else log_failure("wb_ack missing one cycle after the request");
	a_ack_single: assert property (@(negedge pixel_clk) disable iff (reset)
		wb_ack |=> !wb_ack)
		else log_failure("wb_ack high for more than one cycle");
	a_read_data: assert property (@(negedge pixel_clk) disable iff (reset)
		(wb_ack && !wb_we) |-> (wb_dat_r == exp_rdata))
		else log_failure($sformatf("read data %h, expected %h", wb_dat_r, exp_rdata));
	a_line_len: assert property (@(negedge pixel_clk) disable iff (reset)
		(h_fall && lines_seen) |-> (line_cycles == H_TOTAL))
		else log_failure($sformatf("line of %0d cycles", line_cycles));
	a_hsync_width: assert property (@(negedge pixel_clk) disable iff (reset)
		(h_rise && lines_seen) |-> (hs_low == H_SYNC))
		else log_failure($sformatf("hsync low for %0d cycles", hs_low));
	a_frame_lines: assert property (@(negedge pixel_clk) disable iff (reset)
		(v_fall && frames_seen) |-> (lines == V_TOTAL))
		else log_failure($sformatf("frame of %0d lines", lines));
	a_vsync_width: assert property (@(negedge pixel_clk) disable iff (reset)
		(v_rise && frames_seen) |-> (vs_low_lines == V_SYNC))
		else log_failure($sformatf("vsync low for %0d lines", vs_low_lines));
	a_active_count: assert property (@(negedge pixel_clk) disable iff (reset)
		(v_fall && frames_seen) |-> (on_count == H_ACTIVE * V_ACTIVE))
		else log_failure($sformatf("%0d active pixels in a frame", on_count));
	a_blank: assert property (@(negedge pixel_clk) disable iff (reset)
		!video_on |-> (colour == '0))
		else log_failure($sformatf("colour %h outside the active area", colour));
	a_border: assert property (@(negedge pixel_clk) disable iff (reset)
		(check_mode == CHK_BORDER && video_on) |-> (colour == border_color(col, row)))
		else log_failure($sformatf("border colour %h at (%0d,%0d)", colour, col, row));
	a_bars: assert property (@(negedge pixel_clk) disable iff (reset)
		(check_mode == CHK_BARS && video_on) |-> (colour == bar_color(col)))
		else log_failure($sformatf("bar colour %h at (%0d,%0d)", colour, col, row));
	a_game: assert property (@(negedge pixel_clk) disable iff (reset)
		(check_mode == CHK_GAME && video_on) |-> (colour == game_color(col, row)))
		else log_failure($sformatf("game colour %h at (%0d,%0d), expected %h",
			colour, col, row, game_color(col, row)));

	//////////////////////////////////////////////////////////////////////
	// stimulus
	//////////////////////////////////////////////////////////////////////

	// somewhere in the active area well away from the frame pulse
	task automatic wait_active();
		do begin
			@(negedge pixel_clk);
		end while (!video_on);
	endtask

	task automatic wait_ack();
		do begin
			@(negedge pixel_clk);
		end while (!wb_ack);
		@(posedge pixel_clk);
		wb_cyc <= 1'b0;
		wb_stb <= 1'b0;
		wb_we <= 1'b0;
	endtask

	task automatic wb_write(input logic adr, input logic [7:0] data);
		wait_active();
		@(posedge pixel_clk);
		wb_cyc <= 1'b1;
		wb_stb <= 1'b1;
		wb_we <= 1'b1;
		wb_adr <= adr;
		wb_dat_w <= data;
		wait_ack();
		if (adr) begin
			spd_x = data[3:2];
			spd_y = data[1:0];
		end else begin
			mode_sh = data[1:0];
		end
	endtask

	task automatic wb_read(input logic adr);
		wait_active();
		@(posedge pixel_clk);
		// unused bits read as zero
		exp_rdata <= adr ? {4'b0000, spd_x, spd_y} : {6'b000000, mode_sh};
		wb_cyc <= 1'b1;
		wb_stb <= 1'b1;
		wb_we <= 1'b0;
		wb_adr <= adr;
		wait_ack();
	endtask

	task automatic wait_frames(input int n);
		repeat (n) @(negedge vsync);
	endtask

	task automatic set_buttons(input logic down, input logic right);
		wait_active();
		@(posedge pixel_clk);
		btn_down <= down;
		btn_right <= right;
	endtask

	task automatic finish_test(input string name);
		tests_done++;
		$display("test %0d %s: %0d failed checks", tests_done, name,
			errors - errors_at_start);
		errors_at_start = errors;
	endtask

	initial begin
		reset = 1'b1;
		btn_up = 1'b0;
		btn_down = 1'b0;
		btn_left = 1'b0;
		btn_right = 1'b0;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = 1'b0;
		wb_dat_w = 8'h00;
		errors = 0;
		errors_at_start = 0;
		tests_done = 0;
		check_mode = CHK_NONE;
		// register reset values
		mode_sh = 2'd0;
		spd_x = 2'd1;
		spd_y = 2'd1;
		exp_rdata = 8'h00;
		repeat (3) @(posedge pixel_clk);
		reset <= 1'b0;

		wb_read(1'b0);
		wb_read(1'b1);
		wb_write(1'b0, 8'hfe);
		wb_read(1'b0);
		wb_write(1'b1, 8'hf6);
		wb_read(1'b1);
		wb_write(1'b0, 8'h00);
		wb_write(1'b1, 8'h05);
		finish_test("register access");

		// raster assertions run all the time
		wait_frames(3);
		finish_test("raster timing");

		wb_write(1'b0, 8'h01);
		wait_frames(1);
		check_mode = CHK_BORDER;
		wait_frames(2);
		check_mode = CHK_NONE;
		finish_test("border pattern");

		wb_write(1'b0, 8'h02);
		wait_frames(1);
		check_mode = CHK_BARS;
		wait_frames(2);
		check_mode = CHK_NONE;
		finish_test("colour bars");

		// faster pucks and enough frames for bounces
		wb_write(1'b1, 8'h0e);
		wb_write(1'b0, 8'h00);
		wait_frames(1);
		check_mode = CHK_GAME;
		wait_frames(12);
		finish_test("puck motion");

		// long enough to reach the right limit
		set_buttons(1'b1, 1'b1);
		wait_frames(16);
		set_buttons(1'b0, 1'b0);
		wait_frames(2);
		check_mode = CHK_NONE;
		finish_test("paddle motion");

		$display("%0d tests run, %0d failed checks", tests_done, errors);
		if (errors == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

// ==== all.f ====
hdl/pong_pkg.sv
hdl/video_timing_if.sv
hdl/video_timing.sv
hdl/pong_regs.sv
hdl/puck_motion.sv
hdl/paddle_motion.sv
hdl/round_puck.sv
hdl/delay_line.sv
hdl/pixel_mux.sv
hdl/pong_top.sv
tests/tb_pong.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module tb_pong -f all.f -o tb_pong
out=$(./obj_dir/tb_pong)
echo "$out"
echo "$out" | grep -q "All tests passed"
